// ==== rtl/fragment_fifo.sv ====
/*
 * Eight-entry fragment FIFO with a combinational head.
 * A push while full or a pop while empty is ignored, so the producer
 * gates push_en with full and the consumer checks empty first.
 * Push and pop in the same cycle keep the occupancy unchanged.
 */
module fragment_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push_en,
    input  zbuf_pkg::sample_addr_t push_addr,
    input  raster_pkg::depth_t     push_depth,
    input  raster_pkg::color_t     push_color,
    input  logic                   pop_en,
    output logic                   full,
    output logic                   empty,
    output zbuf_pkg::sample_addr_t head_addr,
    output raster_pkg::depth_t     head_depth,
    output raster_pkg::color_t     head_color
);

    zbuf_pkg::sample_addr_t addr_mem  [zbuf_pkg::fifo_depth];
    raster_pkg::depth_t     depth_mem [zbuf_pkg::fifo_depth];
    raster_pkg::color_t     color_mem [zbuf_pkg::fifo_depth];

    zbuf_pkg::fifo_ptr_t   wr_ptr;
    zbuf_pkg::fifo_ptr_t   rd_ptr;
    zbuf_pkg::fifo_count_t count;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (count == zbuf_pkg::fifo_count_t'(zbuf_pkg::fifo_depth));
    assign empty   = (count == '0);
    assign do_push = push_en && !full;
    assign do_pop  = pop_en && !empty;

    assign head_addr  = addr_mem[rd_ptr];  // Valid whenever not empty
    assign head_depth = depth_mem[rd_ptr];
    assign head_color = color_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[wr_ptr]  <= push_addr;
            depth_mem[wr_ptr] <= push_depth;
            color_mem[wr_ptr] <= push_color;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at 8
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
        end
    end

endmodule

// ==== rtl/raster_pkg.sv ====
/*
 * Incoming hit sample format for the rasterizer back end.
 * Coordinates are unsigned fixed point with coord_frac fraction bits.
 * Negative coordinates cannot be represented, so the source clamps them.
 * Depth compares as an unsigned number and a smaller value is nearer.
 * Colour is packed R in the top byte, then G, then B.
 */
package raster_pkg;

    localparam int coord_bits      = 12;                   // Whole coordinate width
    localparam int coord_frac      = 4;                    // Fraction bits
    localparam int depth_bits      = 16;
    localparam int color_chan_bits = 8;                    // Per channel
    localparam int color_bits      = 3 * color_chan_bits;  // Packed RGB

    typedef logic [coord_bits-1:0] coord_t;  // Screen coordinate, 8.4 fixed point
    typedef logic [depth_bits-1:0] depth_t;  // Smaller is nearer
    typedef logic [color_bits-1:0] color_t;  // {R, G, B}

    // Samples per pixel; the subsample grid side is 1, 2 or 4
    typedef enum logic [1:0] {
        aa_1x  = 2'd0,  // One sample at the pixel
        aa_4x  = 2'd1,  // 2x2 grid, one fraction bit per axis
        aa_16x = 2'd2   // 4x4 grid, two fraction bits per axis
    } aa_mode_t;

endpackage

// ==== rtl/raster_zbuff_top.sv ====
/*
 * Depth buffer subsystem: decoder, fragment FIFO and buffer core.
 * idle means no fragment is held anywhere and no clear is running.
 * Memory contents are undefined after reset until a clear completes.
 */
module raster_zbuff_top (
    input  logic                 clk,
    input  logic                 reset,
    input  raster_pkg::aa_mode_t aa_mode,
    input  logic                 hit_valid,
    input  raster_pkg::coord_t   hit_x,
    input  raster_pkg::coord_t   hit_y,
    input  raster_pkg::depth_t   hit_depth,
    input  raster_pkg::color_t   hit_color,
    input  logic                 clear,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  zbuf_pkg::wb_addr_t   adr,
    output logic                 hit_ready,
    output logic                 clear_busy,
    output logic                 ack,
    output zbuf_pkg::wb_data_t   dat_r,
    output logic                 idle
);

    logic                   frag_valid;
    logic                   frag_ready;
    zbuf_pkg::sample_addr_t frag_addr;
    raster_pkg::depth_t     frag_depth;
    raster_pkg::color_t     frag_color;
    logic                   push_en;
    logic                   full;
    logic                   empty;
    logic                   pop_en;
    logic                   busy;
    zbuf_pkg::sample_addr_t head_addr;
    raster_pkg::depth_t     head_depth;
    raster_pkg::color_t     head_color;

    assign frag_ready = !full;                     // FIFO back-pressure
    assign push_en    = frag_valid && frag_ready;
    assign idle       = !frag_valid && empty && !busy;  // busy covers clear and in-flight

    sample_decode u_decode (
        .clk(clk), .reset(reset), .aa_mode(aa_mode),
        .hit_valid(hit_valid), .hit_x(hit_x), .hit_y(hit_y),
        .hit_depth(hit_depth), .hit_color(hit_color), .frag_ready(frag_ready),
        .hit_ready(hit_ready), .frag_valid(frag_valid), .frag_addr(frag_addr),
        .frag_depth(frag_depth), .frag_color(frag_color)
    );

    fragment_fifo u_fifo (
        .clk(clk), .reset(reset), .push_en(push_en),
        .push_addr(frag_addr), .push_depth(frag_depth), .push_color(frag_color),
        .pop_en(pop_en), .full(full), .empty(empty),
        .head_addr(head_addr), .head_depth(head_depth), .head_color(head_color)
    );

    zbuffer_core u_core (
        .clk(clk), .reset(reset), .clear(clear), .empty(empty),
        .head_addr(head_addr), .head_depth(head_depth), .head_color(head_color),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .pop_en(pop_en), .clear_busy(clear_busy), .busy(busy),
        .ack(ack), .dat_r(dat_r)
    );

endmodule

// ==== rtl/sample_decode.sv ====
/*
 * Registers one hit and turns it into a sample address.
 * Integer coordinate bits above the pixel field must be zero, otherwise
 * the hit is accepted and dropped. aa_mode is sampled when a hit is
 * accepted, so change it only while the pipeline is idle.
 */
module sample_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  raster_pkg::aa_mode_t   aa_mode,
    input  logic                   hit_valid,
    input  raster_pkg::coord_t     hit_x,
    input  raster_pkg::coord_t     hit_y,
    input  raster_pkg::depth_t     hit_depth,
    input  raster_pkg::color_t     hit_color,
    input  logic                   frag_ready,
    output logic                   hit_ready,
    output logic                   frag_valid,
    output zbuf_pkg::sample_addr_t frag_addr,
    output raster_pkg::depth_t     frag_depth,
    output raster_pkg::color_t     frag_color
);

    logic [zbuf_pkg::pix_bits-1:0] pix_x;
    logic [zbuf_pkg::pix_bits-1:0] pix_y;
    logic [zbuf_pkg::ss_bits-1:0]  ss_x;
    logic [zbuf_pkg::ss_bits-1:0]  ss_y;
    logic                          on_screen;
    logic                          accept;

    assign pix_x = hit_x[raster_pkg::coord_frac +: zbuf_pkg::pix_bits];  // Integer bits 6..4
    assign pix_y = hit_y[raster_pkg::coord_frac +: zbuf_pkg::pix_bits];

    // Anything set in integer bits 7 and up is past the 8 pixel edge
    assign on_screen =
        (hit_x[raster_pkg::coord_bits-1:raster_pkg::coord_frac+zbuf_pkg::pix_bits] == '0) &&
        (hit_y[raster_pkg::coord_bits-1:raster_pkg::coord_frac+zbuf_pkg::pix_bits] == '0);

    always_comb begin
        case (aa_mode)
            raster_pkg::aa_4x: begin  // Top fraction bit only
                ss_x = {{(zbuf_pkg::ss_bits-1){1'b0}}, hit_x[raster_pkg::coord_frac-1]};
                ss_y = {{(zbuf_pkg::ss_bits-1){1'b0}}, hit_y[raster_pkg::coord_frac-1]};
            end
            raster_pkg::aa_16x: begin  // Top two fraction bits
                ss_x = hit_x[raster_pkg::coord_frac-1 -: zbuf_pkg::ss_bits];
                ss_y = hit_y[raster_pkg::coord_frac-1 -: zbuf_pkg::ss_bits];
            end
            default: begin  // aa_1x, subsample 0
                ss_x = '0;
                ss_y = '0;
            end
        endcase
    end

    assign hit_ready = !frag_valid || frag_ready;  // Stage empty or draining now
    assign accept    = hit_valid && hit_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            frag_valid <= 1'b0;
        end else if (accept) begin
            frag_valid <= on_screen;  // Culled hits leave the stage empty
        end else if (frag_ready) begin
            frag_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && on_screen) begin
            frag_addr  <= {pix_y, pix_x, ss_y, ss_x};
            frag_depth <= hit_depth;
            frag_color <= hit_color;
        end
    end

endmodule

// ==== rtl/zbuf_pkg.sv ====
/*
 * Depth buffer geometry and host port layout.
 * The screen is fixed at 8 by 8 pixels, with room for a 4x4 subsample
 * grid in every pixel whatever the anti-aliasing mode.
 * Sample address is {pixel y, pixel x, subsample y, subsample x}.
 * Wishbone address bit 10 selects depth (1) or colour (0).
 */
package zbuf_pkg;

    localparam int pix_bits         = 3;                          // 8 pixels per axis
    localparam int ss_bits          = 2;                          // 4 subsamples per axis
    localparam int sample_addr_bits = 2 * (pix_bits + ss_bits);   // 10
    localparam int sample_count     = 1 << sample_addr_bits;      // 1024 samples

    typedef logic [sample_addr_bits-1:0] sample_addr_t;

    localparam int fifo_depth    = 8;                     // Fragment FIFO entries
    localparam int fifo_ptr_bits = $clog2(fifo_depth);

    typedef logic [fifo_ptr_bits-1:0] fifo_ptr_t;
    typedef logic [fifo_ptr_bits:0]   fifo_count_t;        // Holds 0..fifo_depth

    localparam raster_pkg::depth_t depth_clear = '1;      // Farthest possible
    localparam raster_pkg::color_t color_clear = '0;      // Black

    localparam int wb_sel_bit = sample_addr_bits;         // 1 = depth, 0 = colour

    typedef logic [sample_addr_bits:0]               wb_addr_t;
    typedef logic [$bits(raster_pkg::color_t)-1:0]   wb_data_t;  // Depth zero-extended

endpackage

// ==== rtl/zbuffer_core.sv ====
/*
 * Depth and colour memories with one shared port, 1024 samples each.
 * Port priority is clear, then Wishbone, then fragments. A clear takes
 * 1024 cycles and restarts any Wishbone access or fragment read it cuts
 * off; the fragment stays in the FIFO until its write cycle pops it.
 * Wishbone writes are acknowledged and dropped. Memory has no reset.
 */
module zbuffer_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   clear,
    input  logic                   empty,
    input  zbuf_pkg::sample_addr_t head_addr,
    input  raster_pkg::depth_t     head_depth,
    input  raster_pkg::color_t     head_color,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  zbuf_pkg::wb_addr_t     adr,
    output logic                   pop_en,
    output logic                   clear_busy,
    output logic                   busy,
    output logic                   ack,
    output zbuf_pkg::wb_data_t     dat_r
);

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_frag_read,
        st_frag_write,
        st_wb_read,
        st_wb_ack
    } state_t;

    state_t state;
    state_t state_nxt;

    raster_pkg::depth_t depth_mem [zbuf_pkg::sample_count];
    raster_pkg::color_t color_mem [zbuf_pkg::sample_count];

    zbuf_pkg::sample_addr_t clr_addr;   // Clear sweep position
    zbuf_pkg::sample_addr_t mem_addr;   // Read address
    zbuf_pkg::sample_addr_t wr_addr;
    raster_pkg::depth_t     wr_depth;
    raster_pkg::color_t     wr_color;
    raster_pkg::depth_t     rd_depth;   // Read data, one cycle after address
    raster_pkg::color_t     rd_color;
    logic                   wr_en;
    logic                   wb_req;
    logic                   start_clear;
    logic                   frag_wins;

    assign wb_req      = cyc && stb;
    assign start_clear = clear && (state != st_clear);  // Ignored mid-clear
    assign frag_wins   = (head_depth < rd_depth);       // Strictly nearer only

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (wb_req) state_nxt = st_wb_read;
                else if (!empty) state_nxt = st_frag_read;
            end
            st_clear: begin
                if (clr_addr == zbuf_pkg::sample_addr_t'(zbuf_pkg::sample_count - 1)) begin
                    state_nxt = st_idle;  // Last sample written this cycle
                end
            end
            st_frag_read: state_nxt = st_frag_write;
            st_frag_write: state_nxt = st_idle;
            st_wb_read: state_nxt = st_wb_ack;
            st_wb_ack: state_nxt = st_idle;
            default: state_nxt = st_idle;
        endcase
        if (start_clear) state_nxt = st_clear;  // Clear preempts everything
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            clr_addr <= '0;
        end else begin
            state <= state_nxt;
            if (start_clear) clr_addr <= '0;
            else if (state == st_clear) clr_addr <= clr_addr + 1'b1;
        end
    end

    // Read address follows the Wishbone request only while it owns the port
    assign mem_addr = (state == st_wb_read) ? adr[zbuf_pkg::sample_addr_bits-1:0] : head_addr;

    always_comb begin
        if (state == st_clear) begin
            wr_en    = 1'b1;
            wr_addr  = clr_addr;
            wr_depth = zbuf_pkg::depth_clear;
            wr_color = zbuf_pkg::color_clear;
        end else begin
            wr_en    = (state == st_frag_write) && frag_wins;
            wr_addr  = head_addr;
            wr_depth = head_depth;
            wr_color = head_color;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            depth_mem[wr_addr] <= wr_depth;
            color_mem[wr_addr] <= wr_color;
        end
        rd_depth <= depth_mem[mem_addr];  // Old data on a same-address write
        rd_color <= color_mem[mem_addr];
    end

    assign pop_en     = (state == st_frag_write);  // Head leaves after its write
    assign clear_busy = (state == st_clear);
    assign busy       = (state != st_idle);
    assign ack        = (state == st_wb_ack);

    always_comb begin
        if (we) begin
            dat_r = '0;  // Writes return nothing
        end else if (adr[zbuf_pkg::wb_sel_bit]) begin
            dat_r = {{($bits(zbuf_pkg::wb_data_t) - $bits(raster_pkg::depth_t)){1'b0}},
                     rd_depth};
        end else begin
            dat_r = rd_color;
        end
    end

endmodule

// ==== src.f ====
+incdir+verif
rtl/raster_pkg.sv
rtl/zbuf_pkg.sv
rtl/sample_decode.sv
rtl/fragment_fifo.sv
rtl/zbuffer_core.sv
rtl/raster_zbuff_top.sv
verif/tb_zbuff.sv

// ==== verif/zbuff_ref.svh ====
/*
 * Reference depth buffer, included inside the testbench top module.
 * Models the 1024 samples, the sample address rule and the strict
 * less-than depth test. Hits must be applied in acceptance order.
 */
`ifndef ZBUFF_REF_SVH
`define ZBUFF_REF_SVH

raster_pkg::depth_t ref_depth [zbuf_pkg::sample_count];  // Expected depth per sample
raster_pkg::color_t ref_color [zbuf_pkg::sample_count];  // Expected colour per sample

// Sample index of a hit, or -1 when it lands off the 8x8 screen
function automatic int sample_index(input raster_pkg::coord_t x, input raster_pkg::coord_t y,
                                    input raster_pkg::aa_mode_t mode);
    int px;
    int py;
    int sx;
    int sy;
    if ((x >> 7) != 0 || (y >> 7) != 0) begin
        return -1;  // Integer part 8 or more
    end
    px = (x >> 4) & 7;
    py = (y >> 4) & 7;
    case (mode)
        raster_pkg::aa_4x: begin
            sx = (x >> 3) & 1;  // Half-pixel grid
            sy = (y >> 3) & 1;
        end
        raster_pkg::aa_16x: begin
            sx = (x >> 2) & 3;  // Quarter-pixel grid
            sy = (y >> 2) & 3;
        end
        default: begin
            sx = 0;
            sy = 0;
        end
    endcase
    return py * 128 + px * 16 + sy * 4 + sx;  // {py, px, sy, sx}
endfunction

// Equal depth keeps the stored colour
function automatic void apply_hit(input int idx, input raster_pkg::depth_t d,
                                  input raster_pkg::color_t c);
    if (idx >= 0 && d < ref_depth[idx]) begin
        ref_depth[idx] = d;
        ref_color[idx] = c;
    end
endfunction

function automatic void ref_clear();
    for (int i = 0; i < zbuf_pkg::sample_count; i++) begin
        ref_depth[i] = '1;  // Farthest
        ref_color[i] = '0;
    end
endfunction

`endif

// ==== verif/tb_zbuff.sv ====
/*
 * Testbench for the depth buffer subsystem.
 * Every acknowledged Wishbone read is compared with the reference model.
 * Memory is undefined until the first clear completes.
 * Runs stop at the first mismatch or expired wait.
 */
module tb_zbuff;

    localparam int ack_limit   = 3000;  // Read wait in cycles long enough to span a clear
    localparam int ready_limit = 5000;
    localparam int idle_limit  = 3000;

    logic                 clk;
    logic                 reset;
    logic                 hit_valid;
    logic                 clear;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic                 hit_ready;
    logic                 clear_busy;
    logic                 ack;
    logic                 idle;
    raster_pkg::aa_mode_t aa_mode;
    raster_pkg::coord_t   hit_x;
    raster_pkg::coord_t   hit_y;
    raster_pkg::depth_t   hit_depth;
    raster_pkg::color_t   hit_color;
    zbuf_pkg::wb_addr_t   adr;
    zbuf_pkg::wb_data_t   dat_r;

    integer seed;
    int     stall_cycles;                // Cycles a hit waited on hit_ready
    int                 pend_idx [$];    // Hits held back during the burst
    raster_pkg::depth_t pend_depth [$];
    raster_pkg::color_t pend_color [$];

    `include "zbuff_ref.svh"

    raster_zbuff_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    function automatic zbuf_pkg::wb_data_t expected_word(input zbuf_pkg::wb_addr_t a);
        int idx;
        idx = a[9:0];
        if (a[10]) return zbuf_pkg::wb_data_t'(ref_depth[idx]);  // Zero-extended depth
        return ref_color[idx];
    endfunction

    // Compares each read in its ack cycle
    always @(negedge clk) begin
        if (!reset && cyc && stb && !we && ack) begin
            assert (dat_r == expected_word(adr)) else
                abort_run($sformatf("Fail at time %0t: adr %h read %h, expected %h",
                                    $time, adr, dat_r, expected_word(adr)));
        end
    end

    task automatic wb_read(input zbuf_pkg::wb_addr_t a, output zbuf_pkg::wb_data_t d);
        int waited;
        waited = 0;
        @(posedge clk);
        cyc <= 1'b1;  // Held until the caller releases the bus
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        @(negedge clk);
        while (!ack && waited < ack_limit) begin
            waited++;
            @(negedge clk);
        end
        if (!ack) abort_run("Timeout: no Wishbone ack for a read");
        else d = dat_r;
    endtask

    task automatic release_bus();
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic check_all();
        zbuf_pkg::wb_data_t d;
        for (int i = 0; i < zbuf_pkg::sample_count; i++) begin
            wb_read({1'b1, zbuf_pkg::sample_addr_t'(i)}, d);  // Depth half
            wb_read({1'b0, zbuf_pkg::sample_addr_t'(i)}, d);  // Colour half
        end
        release_bus();
    endtask

    task automatic run_clear(input bit wait_done);
        int busy_cycles;
        busy_cycles = 0;
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;  // One-cycle pulse
        ref_clear();
        @(negedge clk);
        while (wait_done && clear_busy && busy_cycles < 2000) begin
            busy_cycles++;
            @(negedge clk);
        end
        if (wait_done && clear_busy) abort_run("Timeout: clear_busy stayed high");
        else if (wait_done) begin
            assert (busy_cycles == zbuf_pkg::sample_count) else
                abort_run($sformatf("Fail at time %0t: clear_busy high %0d cycles, expected %0d",
                                    $time, busy_cycles, zbuf_pkg::sample_count));
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!idle && waited < idle_limit) begin
            waited++;
            @(negedge clk);
        end
        if (!idle) abort_run("Timeout: DUT did not return to idle");
    endtask

    // Transfer happens on the edge after hit_ready is seen high
    task automatic drive_hit(input raster_pkg::coord_t x, input raster_pkg::coord_t y,
                             input raster_pkg::depth_t d, input raster_pkg::color_t c,
                             input bit defer);
        int idx;
        int waited;
        idx = sample_index(x, y, aa_mode);
        waited = 0;
        if (defer) begin
            pend_idx.push_back(idx);
            pend_depth.push_back(d);
            pend_color.push_back(c);
        end else begin
            apply_hit(idx, d, c);
        end
        @(posedge clk);
        hit_valid <= 1'b1;
        hit_x     <= x;
        hit_y     <= y;
        hit_depth <= d;
        hit_color <= c;
        @(negedge clk);
        while (!hit_ready && waited < ready_limit) begin
            waited++;
            stall_cycles++;
            @(negedge clk);
        end
        if (!hit_ready) abort_run("Timeout: hit_ready stayed low");
    endtask

    task automatic end_hits();
        @(posedge clk);
        hit_valid <= 1'b0;
    endtask

    task automatic random_hits(input int count, input bit off_screen, input bit defer);
        raster_pkg::coord_t x;
        raster_pkg::coord_t y;
        raster_pkg::coord_t far;
        for (int i = 0; i < count; i++) begin
            x   = raster_pkg::coord_t'($random(seed) & 32'h7F);  // Integer part 0..7
            y   = raster_pkg::coord_t'($random(seed) & 32'h7F);
            far = raster_pkg::coord_t'(($random(seed) & 32'hF00) | 32'h080);  // 8 or more
            if (off_screen && (i % 2 == 1)) x = x | far;
            else if (off_screen) y = y | far;
            drive_hit(x, y, raster_pkg::depth_t'($random(seed)),
                      raster_pkg::color_t'($random(seed)), defer);
        end
        end_hits();
    endtask

    initial begin
        zbuf_pkg::wb_data_t d;
        seed         = 60;
        stall_cycles = 0;
        reset        = 1'b1;
        aa_mode      = raster_pkg::aa_1x;
        hit_valid    = 1'b0;
        hit_x        = '0;
        hit_y        = '0;
        hit_depth    = '0;
        hit_color    = '0;
        clear        = 1'b0;
        cyc          = 1'b0;
        stb          = 1'b0;
        we           = 1'b0;
        adr          = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        run_clear(1'b1);
        wait_idle();
        check_all();  // Whole buffer at clear values

        random_hits(200, 1'b0, 1'b0);  // Nearest hit wins in aa_1x
        wait_idle();
        check_all();

        run_clear(1'b1);  // Pixel (2,3) is sample 416 in aa_1x
        drive_hit(12'h020, 12'h030, 16'd1000, 24'h112233, 1'b0);
        drive_hit(12'h020, 12'h030, 16'd1000, 24'h445566, 1'b0);
        end_hits();
        wait_idle();
        wb_read(11'd416, d);
        release_bus();
        assert (d == 24'h112233) else
            abort_run($sformatf("Fail at time %0t: equal depth changed colour to %h", $time, d));
        drive_hit(12'h020, 12'h030, 16'd999, 24'h778899, 1'b0);
        end_hits();
        wait_idle();
        wb_read(11'd416, d);
        release_bus();
        assert (d == 24'h778899) else
            abort_run($sformatf("Fail at time %0t: nearer hit left colour %h", $time, d));

        random_hits(60, 1'b1, 1'b0);  // All culled
        wait_idle();
        check_all();

        @(posedge clk);
        aa_mode <= raster_pkg::aa_4x;
        run_clear(1'b1);
        random_hits(150, 1'b0, 1'b0);
        wait_idle();
        check_all();

        @(posedge clk);
        aa_mode <= raster_pkg::aa_16x;
        run_clear(1'b1);
        random_hits(300, 1'b0, 1'b0);
        wait_idle();
        check_all();

        // Burst during a clear while the host keeps the port busy
        run_clear(1'b0);
        stall_cycles = 0;
        fork
            random_hits(40, 1'b0, 1'b1);
            begin
                for (int i = 0; i < 100; i++) begin
                    wb_read(zbuf_pkg::wb_addr_t'(i * 41), d);  // Sees cleared data only
                end
                release_bus();
            end
        join
        wait_idle();
        foreach (pend_idx[i]) apply_hit(pend_idx[i], pend_depth[i], pend_color[i]);
        assert (stall_cycles > 0) else abort_run("hit_ready never dropped during the burst");
        check_all();

        $display("Simulation PASSED");
        $finish;
    end

endmodule
